//--- verilog/vrf_pkg.sv
/*
 * Geometry of the banked vector register file of one lane
 * Plain vector types for data, strobes, addresses and instruction ids
 */
`default_nettype none

package vrf_pkg;

  //////////////////////////////////////////////////////////////////////
  // Geometry
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned NR_BANKS    = 4;
  localparam int unsigned NR_VINSN    = 4;
  localparam int unsigned NR_OPQUEUES = 2;
  localparam int unsigned VREG_WORDS  = 8;
  localparam int unsigned NR_VREGS    = 32;

  // Derived widths
  localparam int unsigned ELEN        = 64;
  localparam int unsigned VLEN_W      = 8;
  localparam int unsigned VREG_IDX_W  = $clog2(NR_VREGS);
  localparam int unsigned BANK_IDX_W  = $clog2(NR_BANKS);
  localparam int unsigned VADDR_W     = $clog2(NR_VREGS * VREG_WORDS);

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef logic [ELEN-1:0]               elem_t;
  typedef logic [ELEN/8-1:0]             strb_t;
  // Word address over the whole VRF, bank select in the low bits
  typedef logic [VADDR_W-1:0]            vaddr_t;
  typedef logic [BANK_IDX_W-1:0]         bank_idx_t;
  typedef logic [VADDR_W-BANK_IDX_W-1:0] bank_addr_t;
  typedef logic [$clog2(NR_VINSN)-1:0]   vid_t;
  typedef logic [VLEN_W-1:0]             vlen_t;
  // One bit per in-flight instruction
  typedef logic [NR_VINSN-1:0]           vinsn_vec_t;

endpackage

`default_nettype wire

//--- verilog/opstage_pkg.sv
/*
 * Operand stage types
 * Element width and requester state encodings
 * Operand request, write-back request and bank access structs
 */
`default_nettype none

package opstage_pkg;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } ew_e;

  typedef enum logic {
    IDLE,
    REQUESTING
  } req_state_e;

  //////////////////////////////////////////////////////////////////////
  // Transactions
  //////////////////////////////////////////////////////////////////////

  // Read of one vector operand, issued by the lane sequencer
  typedef struct packed {
    vrf_pkg::vid_t                       id;
    logic [vrf_pkg::VREG_IDX_W-1:0]      vs;
    vrf_pkg::vlen_t                      vl;
    ew_e                                 eew;
    // Instructions whose results this read must not overtake
    vrf_pkg::vinsn_vec_t                 hazard;
  } operand_req_t;

  // One result word from a functional unit
  typedef struct packed {
    vrf_pkg::vid_t   id;
    vrf_pkg::vaddr_t addr;
    vrf_pkg::elem_t  wdata;
    vrf_pkg::strb_t  be;
  } wb_req_t;

  // Access presented to one bank, opqueue tags the reader
  typedef struct packed {
    vrf_pkg::bank_addr_t bank_addr;
    logic                wen;
    vrf_pkg::elem_t      wdata;
    vrf_pkg::strb_t      be;
    logic                opqueue;
  } bank_acc_t;

endpackage

`default_nettype wire

//--- verilog/operand_requester.sv
/*
 * Operand requesters, one per operand queue
 * Each walks a vector register word by word and raises bank reads
 * Result-written tracker for the read-after-write stall
 */
`default_nettype none

module operand_requester (
  input  wire                                                   clk_i,
  input  wire                                                   rst_ni,
  input  wire opstage_pkg::operand_req_t [vrf_pkg::NR_OPQUEUES-1:0] operand_req_i,
  input  wire [vrf_pkg::NR_OPQUEUES-1:0]                        operand_req_valid_i,
  output logic [vrf_pkg::NR_OPQUEUES-1:0]                       operand_req_ready_o,
  output logic [vrf_pkg::NR_OPQUEUES-1:0]                       opqueue_cmd_valid_o,
  input  wire [vrf_pkg::NR_OPQUEUES-1:0]                        operand_queue_ready_i,
  output logic [vrf_pkg::NR_OPQUEUES-1:0]                       rd_valid_o,
  output vrf_pkg::bank_idx_t [vrf_pkg::NR_OPQUEUES-1:0]         rd_bank_o,
  output opstage_pkg::bank_acc_t [vrf_pkg::NR_OPQUEUES-1:0]     rd_acc_o,
  input  wire [vrf_pkg::NR_OPQUEUES-1:0]                        rd_gnt_i,
  output logic [vrf_pkg::NR_OPQUEUES-1:0]                       operand_issued_o,
  input  wire vrf_pkg::vinsn_vec_t                              wr_done_i
);

  import vrf_pkg::*;
  import opstage_pkg::*;

  typedef struct packed {
    vid_t       id;
    vaddr_t     addr;
    vlen_t      len;
    vinsn_vec_t hazard;
  } req_ctx_t;

  // Words needed for vl elements, 8 >> eew elements per word, rounded up
  function automatic vlen_t word_count(vlen_t vl, ew_e eew);
    logic [1:0]      shift;
    logic [VLEN_W:0] per_word;
    logic [VLEN_W:0] rounded;
    shift    = 2'(EW64) - 2'(eew);
    per_word = (VLEN_W + 1)'(1) << shift;
    rounded  = {1'b0, vl} + per_word - 1'b1;
    return vlen_t'(rounded >> shift);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Result-written tracker
  //////////////////////////////////////////////////////////////////////

  // Writes granted last cycle, each one lets one dependent read go
  vinsn_vec_t wr_done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_done_q <= '0;
    end else begin
      wr_done_q <= wr_done_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Per-queue requesters
  //////////////////////////////////////////////////////////////////////

  for (genvar q = 0; q < NR_OPQUEUES; q++) begin : gen_queue
    req_state_e state_d;
    req_state_e state_q;
    req_ctx_t   ctx_d;
    req_ctx_t   ctx_q;
    logic       stall;
    logic       last_word;
    logic       accept;

    // An instruction never waits on its own results
    assign stall = |(ctx_q.hazard & ~wr_done_q & ~(vinsn_vec_t'(1) << ctx_q.id));

    assign rd_valid_o[q] = (state_q == REQUESTING) && operand_queue_ready_i[q] && !stall;
    assign rd_bank_o[q]  = ctx_q.addr[BANK_IDX_W-1:0];
    assign rd_acc_o[q]   = '{
      bank_addr: ctx_q.addr[VADDR_W-1:BANK_IDX_W],
      wen:       1'b0,
      wdata:     '0,
      be:        '0,
      opqueue:   1'(q)
    };
    assign operand_issued_o[q] = rd_gnt_i[q];

    // The last grant frees the requester in the same cycle
    assign last_word = rd_gnt_i[q] && (ctx_q.len == vlen_t'(1));
    assign accept    = operand_req_valid_i[q] && ((state_q == IDLE) || last_word);

    assign operand_req_ready_o[q] = accept;
    assign opqueue_cmd_valid_o[q] = accept && (operand_req_i[q].vl != '0);

    always_comb begin
      state_d = state_q;
      ctx_d   = ctx_q;

      if (rd_gnt_i[q]) begin
        ctx_d.addr = ctx_q.addr + 1'b1;
        ctx_d.len  = ctx_q.len - 1'b1;
        if (last_word) begin
          state_d = IDLE;
        end
      end

      if (accept) begin
        ctx_d.id     = operand_req_i[q].id;
        ctx_d.hazard = operand_req_i[q].hazard;
        ctx_d.addr   = vaddr_t'(operand_req_i[q].vs) * vaddr_t'(VREG_WORDS);
        ctx_d.len    = word_count(operand_req_i[q].vl, operand_req_i[q].eew);
        // An empty operand is acknowledged and dropped
        state_d      = (operand_req_i[q].vl != '0) ? REQUESTING : IDLE;
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        state_q <= IDLE;
        ctx_q   <= '0;
      end else begin
        state_q <= state_d;
        ctx_q   <= ctx_d;
      end
    end

    a_no_read_in_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
      rd_gnt_i[q] |-> (rd_valid_o[q] && (state_q == REQUESTING)));

    a_len_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (state_q == REQUESTING) |-> (ctx_q.len != '0));
  end

endmodule

`default_nettype wire

//--- verilog/result_stream_reg.sv
/*
 * One-entry stream register for load-unit results
 * Final-grant pulse one cycle after the buffered write reaches the VRF
 */
`default_nettype none

module result_stream_reg (
  input  wire                       clk_i,
  input  wire                       rst_ni,
  input  wire opstage_pkg::wb_req_t wb_i,
  input  wire                       wb_req_i,
  output logic                      wb_gnt_o,
  output opstage_pkg::wb_req_t      buf_o,
  output logic                      buf_req_o,
  input  wire                       buf_gnt_i,
  output logic                      final_gnt_o
);

  import opstage_pkg::*;

  wb_req_t data_q;
  logic    full_q;
  logic    accept;

  // Room when empty or when the held entry drains this cycle
  assign accept    = wb_req_i && (!full_q || buf_gnt_i);
  assign wb_gnt_o  = accept;
  assign buf_o     = data_q;
  assign buf_req_o = full_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q      <= 1'b0;
      final_gnt_o <= 1'b0;
    end else begin
      if (accept) begin
        full_q <= 1'b1;
      end else if (buf_gnt_i) begin
        full_q <= 1'b0;
      end
      // Dependency is released only once the word is in the bank
      final_gnt_o <= buf_gnt_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      data_q <= wb_i;
    end
  end

  a_buf_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (buf_req_o && !buf_gnt_i) |=> (buf_req_o && $stable(buf_o)));

endmodule

`default_nettype wire

//--- verilog/vrf_bank_arbiter.sv
/*
 * Per-bank arbitration of operand reads and result writes
 * Round-robin inside each priority level, the high level always wins
 */
`default_nettype none

module vrf_bank_arbiter (
  input  wire                                               clk_i,
  input  wire                                               rst_ni,
  input  wire [vrf_pkg::NR_OPQUEUES-1:0]                    rd_valid_i,
  input  wire vrf_pkg::bank_idx_t [vrf_pkg::NR_OPQUEUES-1:0] rd_bank_i,
  input  wire opstage_pkg::bank_acc_t [vrf_pkg::NR_OPQUEUES-1:0] rd_acc_i,
  output logic [vrf_pkg::NR_OPQUEUES-1:0]                   rd_gnt_o,
  input  wire opstage_pkg::wb_req_t                         alu_wb_i,
  input  wire                                               alu_wb_req_i,
  output logic                                              alu_wb_gnt_o,
  input  wire opstage_pkg::wb_req_t                         ldu_buf_i,
  input  wire                                               ldu_buf_req_i,
  output logic                                              ldu_buf_gnt_o,
  output logic [vrf_pkg::NR_BANKS-1:0]                      vrf_req_o,
  output opstage_pkg::bank_acc_t [vrf_pkg::NR_BANKS-1:0]    vrf_acc_o
);

  import vrf_pkg::*;
  import opstage_pkg::*;

  // Level l groups queue l with write source l, ALU high and load buffer low
  wb_req_t   [NR_OPQUEUES-1:0] wr;
  logic      [NR_OPQUEUES-1:0] wr_req;
  bank_acc_t [NR_OPQUEUES-1:0] wr_acc;
  logic      [NR_OPQUEUES-1:0] wr_gnt;

  // Member 0 of a group is the read and member 1 the write
  logic [NR_BANKS-1:0][NR_OPQUEUES-1:0][1:0] req;
  logic [NR_BANKS-1:0][NR_OPQUEUES-1:0][1:0] gnt;

  assign wr     = {ldu_buf_i, alu_wb_i};
  assign wr_req = {ldu_buf_req_i, alu_wb_req_i};

  assign alu_wb_gnt_o  = wr_gnt[0];
  assign ldu_buf_gnt_o = wr_gnt[1];

  for (genvar l = 0; l < NR_OPQUEUES; l++) begin : gen_wr_acc
    assign wr_acc[l] = '{
      bank_addr: wr[l].addr[VADDR_W-1:BANK_IDX_W],
      wen:       1'b1,
      wdata:     wr[l].wdata,
      be:        wr[l].be,
      opqueue:   1'b0
    };
  end

  //////////////////////////////////////////////////////////////////////
  // Bank arbiters
  //////////////////////////////////////////////////////////////////////

  for (genvar b = 0; b < NR_BANKS; b++) begin : gen_bank
    logic [NR_OPQUEUES-1:0] level_req;
    logic [NR_OPQUEUES-1:0] level_gnt;

    // Lowest requesting level wins, masking all levels below it
    assign level_gnt = level_req & (~level_req + 1'b1);

    for (genvar l = 0; l < NR_OPQUEUES; l++) begin : gen_level
      logic ptr_q;
      logic winner;

      assign req[b][l][0] = rd_valid_i[l] && (rd_bank_i[l] == bank_idx_t'(b));
      assign req[b][l][1] = wr_req[l] && (wr[l].addr[BANK_IDX_W-1:0] == bank_idx_t'(b));
      assign level_req[l] = |req[b][l];

      // Pointer breaks a tie, a lone requester wins outright
      assign winner       = (&req[b][l]) ? ptr_q : req[b][l][1];
      assign gnt[b][l][0] = level_gnt[l] && !winner;
      assign gnt[b][l][1] = level_gnt[l] && winner;

      always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
          ptr_q <= 1'b0;
        end else if (level_gnt[l]) begin
          ptr_q <= !winner;
        end
      end
    end

    a_one_gnt_per_bank: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0(gnt[b]));
  end

  //////////////////////////////////////////////////////////////////////
  // Grant collection and bank access mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_gnt_o  = '0;
    wr_gnt    = '0;
    vrf_req_o = '0;
    vrf_acc_o = '0;
    for (int b = 0; b < NR_BANKS; b++) begin
      vrf_req_o[b] = |gnt[b];
      for (int l = 0; l < NR_OPQUEUES; l++) begin
        rd_gnt_o[l] |= gnt[b][l][0];
        wr_gnt[l]   |= gnt[b][l][1];
        if (gnt[b][l][0]) begin
          vrf_acc_o[b] = rd_acc_i[l];
        end
        if (gnt[b][l][1]) begin
          vrf_acc_o[b] = wr_acc[l];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/operand_stage.sv
/*
 * Operand stage of one vector lane
 * Requesters, load-unit stream register and VRF bank arbiter
 */
`default_nettype none

module operand_stage (
  input  wire                                                   clk_i,
  input  wire                                                   rst_ni,
  input  wire opstage_pkg::operand_req_t [vrf_pkg::NR_OPQUEUES-1:0] operand_req_i,
  input  wire [vrf_pkg::NR_OPQUEUES-1:0]                        operand_req_valid_i,
  output logic [vrf_pkg::NR_OPQUEUES-1:0]                       operand_req_ready_o,
  input  wire [vrf_pkg::NR_OPQUEUES-1:0]                        operand_queue_ready_i,
  output logic [vrf_pkg::NR_OPQUEUES-1:0]                       operand_issued_o,
  output logic [vrf_pkg::NR_OPQUEUES-1:0]                       opqueue_cmd_valid_o,
  input  wire opstage_pkg::wb_req_t                             alu_wb_i,
  input  wire                                                   alu_wb_req_i,
  output logic                                                  alu_wb_gnt_o,
  input  wire opstage_pkg::wb_req_t                             ldu_wb_i,
  input  wire                                                   ldu_wb_req_i,
  output logic                                                  ldu_wb_gnt_o,
  output logic                                                  ldu_wb_final_gnt_o,
  output logic [vrf_pkg::NR_BANKS-1:0]                          vrf_req_o,
  output opstage_pkg::bank_acc_t [vrf_pkg::NR_BANKS-1:0]        vrf_acc_o
);

  import vrf_pkg::*;
  import opstage_pkg::*;

  logic      [NR_OPQUEUES-1:0] rd_valid;
  logic      [NR_OPQUEUES-1:0] rd_gnt;
  bank_idx_t [NR_OPQUEUES-1:0] rd_bank;
  bank_acc_t [NR_OPQUEUES-1:0] rd_acc;
  wb_req_t                     ldu_buf;
  logic                        ldu_buf_req;
  logic                        ldu_buf_gnt;
  vinsn_vec_t                  wr_done;

  // Write grants decoded into one event per instruction id
  for (genvar v = 0; v < NR_VINSN; v++) begin : gen_wr_done
    assign wr_done[v] = (alu_wb_gnt_o && (alu_wb_i.id == vid_t'(v))) ||
                        (ldu_buf_gnt && (ldu_buf.id == vid_t'(v)));
  end

  operand_requester u_requester (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .operand_req_i         (operand_req_i),
    .operand_req_valid_i   (operand_req_valid_i),
    .operand_req_ready_o   (operand_req_ready_o),
    .opqueue_cmd_valid_o   (opqueue_cmd_valid_o),
    .operand_queue_ready_i (operand_queue_ready_i),
    .rd_valid_o            (rd_valid),
    .rd_bank_o             (rd_bank),
    .rd_acc_o              (rd_acc),
    .rd_gnt_i              (rd_gnt),
    .operand_issued_o      (operand_issued_o),
    .wr_done_i             (wr_done)
  );

  result_stream_reg u_ldu_reg (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wb_i        (ldu_wb_i),
    .wb_req_i    (ldu_wb_req_i),
    .wb_gnt_o    (ldu_wb_gnt_o),
    .buf_o       (ldu_buf),
    .buf_req_o   (ldu_buf_req),
    .buf_gnt_i   (ldu_buf_gnt),
    .final_gnt_o (ldu_wb_final_gnt_o)
  );

  vrf_bank_arbiter u_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_valid_i    (rd_valid),
    .rd_bank_i     (rd_bank),
    .rd_acc_i      (rd_acc),
    .rd_gnt_o      (rd_gnt),
    .alu_wb_i      (alu_wb_i),
    .alu_wb_req_i  (alu_wb_req_i),
    .alu_wb_gnt_o  (alu_wb_gnt_o),
    .ldu_buf_i     (ldu_buf),
    .ldu_buf_req_i (ldu_buf_req),
    .ldu_buf_gnt_o (ldu_buf_gnt),
    .vrf_req_o     (vrf_req_o),
    .vrf_acc_o     (vrf_acc_o)
  );

endmodule

`default_nettype wire

//--- verif/tb_operand_stage.sv
/*
 * Testbench for the operand stage
 * Clock, reset, watchdog, access monitor and directed test tasks
 */
`default_nettype none

module tb_operand_stage;

  import vrf_pkg::*;
  import opstage_pkg::*;

  localparam int unsigned NR_TESTS     = 5;
  localparam int unsigned TEST_CYCLES  = 400;
  localparam int unsigned READ_TIMEOUT = 200;

  logic clk;
  logic rst_n;
  operand_req_t [NR_OPQUEUES-1:0] operand_req;
  logic [NR_OPQUEUES-1:0] req_valid, req_ready, queue_ready, issued, cmd_valid;
  wb_req_t alu_wb, ldu_wb;
  logic alu_req, alu_gnt, ldu_req, ldu_gnt, ldu_final;
  logic [NR_BANKS-1:0] vrf_req;
  bank_acc_t [NR_BANKS-1:0] vrf_acc;

  int unsigned errors, test_errors, failed_tests;
  // Last high-level winner on bank 0, 0 for queue 0 and 1 for the ALU
  logic last_high;
  int unsigned rd1_cnt, wr2_cnt;
  logic hazard_on;

  operand_stage uut (
    .clk_i (clk), .rst_ni (rst_n),
    .operand_req_i (operand_req), .operand_req_valid_i (req_valid),
    .operand_req_ready_o (req_ready), .operand_queue_ready_i (queue_ready),
    .operand_issued_o (issued), .opqueue_cmd_valid_o (cmd_valid),
    .alu_wb_i (alu_wb), .alu_wb_req_i (alu_req), .alu_wb_gnt_o (alu_gnt),
    .ldu_wb_i (ldu_wb), .ldu_wb_req_i (ldu_req), .ldu_wb_gnt_o (ldu_gnt),
    .ldu_wb_final_gnt_o (ldu_final), .vrf_req_o (vrf_req), .vrf_acc_o (vrf_acc)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(NR_TESTS * TEST_CYCLES * 10);
    $display("Watchdog expired before the tests completed");
    $display("Simulation failed");
    $finish;
  end

  // Access monitor, samples just before each rising edge
  always @(posedge clk) begin
    if (vrf_req[0] && !vrf_acc[0].wen && !vrf_acc[0].opqueue) last_high <= 1'b0;
    if (alu_gnt && alu_wb.addr[BANK_IDX_W-1:0] == '0) last_high <= 1'b1;
    if (issued[1]) rd1_cnt = rd1_cnt + 1;
    if (alu_gnt && alu_wb.id == vid_t'(2)) wr2_cnt = wr2_cnt + 1;
    if (hazard_on) begin
      assert (rd1_cnt <= wr2_cnt) else begin
        $display("ERR %0t: queue 1 read %0d words after %0d id-2 writes",
                 $time, rd1_cnt, wr2_cnt);
        errors++;
      end
    end
  end

  task automatic expect_true(input logic ok, input string what);
    assert (ok) else begin
      $display("ERR %0t: %s", $time, what);
      errors++;
    end
  endtask

  function automatic int unsigned words_for(input vlen_t vl, input ew_e eew);
    int unsigned per_word;
    per_word = 8 >> int'(eew);
    return (int'(vl) + per_word - 1) / per_word;
  endfunction

  task automatic issue_request(input int q, input int id, input int vs, input vlen_t vl,
                               input ew_e eew, input vinsn_vec_t hazard);
    @(posedge clk);
    operand_req[q] <= '{id: vid_t'(id), vs: 5'(vs), vl: vl, eew: eew, hazard: hazard};
    req_valid[q]   <= 1'b1;
    @(negedge clk);
    expect_true(req_ready[q], "request not accepted");
    expect_true(cmd_valid[q] == (vl != 0), "wrong command valid");
    @(posedge clk);
    req_valid[q] <= 1'b0;
  endtask

  task automatic run_read(input int q, input int vs, input vlen_t vl, input ew_e eew,
                          input vinsn_vec_t hazard);
    int unsigned n, cyc, words;
    vaddr_t addr;
    words = words_for(vl, eew);
    issue_request(q, q, vs, vl, eew, hazard);
    n   = 0;
    cyc = 0;
    while (n < words && cyc < READ_TIMEOUT) begin
      @(negedge clk);
      cyc++;
      if (issued[q]) begin
        addr = vaddr_t'(vs * VREG_WORDS + n);
        expect_true(vrf_req[addr % NR_BANKS], "read missing on its bank");
        expect_true(vrf_acc[addr % NR_BANKS].bank_addr == addr / NR_BANKS, "wrong bank address");
        expect_true(!vrf_acc[addr % NR_BANKS].wen, "read shown as write");
        expect_true(vrf_acc[addr % NR_BANKS].opqueue == 1'(q), "wrong opqueue tag");
        n++;
      end
    end
    if (n != words) begin
      $display("Queue %0d issued %0d of %0d reads before timing out", q, n, words);
      errors++;
    end
    repeat (4) begin
      @(negedge clk);
      expect_true(!issued[q], "read issued beyond the word count");
    end
  endtask

  // Read of queue q against an ALU write, both on bank 0
  task automatic contend_bank0(input int q, input int vs);
    logic alu_first;
    logic retry;
    elem_t data;
    data = {$urandom, $urandom};
    @(posedge clk);
    queue_ready[q] <= 1'b0;
    issue_request(q, q, vs, 8'd1, EW64, '0);
    queue_ready[q] <= 1'b1;
    alu_req        <= 1'b1;
    alu_wb         <= '{id: 2'd1, addr: vaddr_t'(vs * VREG_WORDS), wdata: data, be: '1};
    @(negedge clk);
    alu_first = (q == 1) ? 1'b1 : !last_high;
    // A second ALU write meets the waiting queue-0 read on the high level again
    retry = alu_first && (q == 0);
    expect_true(alu_gnt == alu_first, "wrong ALU grant under contention");
    expect_true(issued[q] == !alu_first, "wrong read grant under contention");
    if (alu_first) expect_true(vrf_acc[0].wen && vrf_acc[0].wdata == data, "ALU data lost");
    @(posedge clk);
    if (alu_first && !retry) alu_req <= 1'b0;
    @(negedge clk);
    expect_true(alu_first ? issued[q] : alu_gnt, "loser not served next cycle");
    if (retry) begin
      @(negedge clk);
      expect_true(alu_gnt, "second ALU write not served");
    end
    @(posedge clk);
    alu_req <= 1'b0;
  endtask

  task automatic load_write(input int addr);
    elem_t data;
    data = {$urandom, $urandom};
    @(posedge clk);
    ldu_req <= 1'b1;
    ldu_wb  <= '{id: 2'd3, addr: vaddr_t'(addr), wdata: data, be: 8'h0f};
    @(negedge clk);
    expect_true(ldu_gnt, "load write refused by an empty buffer");
    @(posedge clk);
    ldu_req <= 1'b0;
    @(negedge clk);
    expect_true(vrf_req[addr % NR_BANKS] && vrf_acc[addr % NR_BANKS].wen, "load write missing");
    expect_true(vrf_acc[addr % NR_BANKS].wdata == data, "load data mismatch");
    expect_true(vrf_acc[addr % NR_BANKS].bank_addr == addr / NR_BANKS, "load address mismatch");
    expect_true(vrf_acc[addr % NR_BANKS].be == 8'h0f, "load byte enables mismatch");
    expect_true(!ldu_final, "final grant too early");
    @(negedge clk);
    expect_true(ldu_final, "final grant missing");
    @(negedge clk);
    expect_true(!ldu_final, "final grant longer than one cycle");
  endtask

  task automatic finish_test(input string name);
    if (errors == test_errors) begin
      $display("test %s: PASS", name);
    end else begin
      $display("test %s: FAIL (%0d errors)", name, errors - test_errors);
      failed_tests++;
    end
    test_errors = errors;
  endtask

  ////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////

  task automatic test_single_read();
    run_read(0, 3, 8'd16, EW64, '0);
    finish_test("single_read");
  endtask

  task automatic test_word_count();
    run_read(0, 7, 8'd10, EW16, '0);
    run_read(1, 2, 8'd0, EW8, '0);
    finish_test("word_count");
  endtask

  task automatic test_priority();
    elem_t w;
    contend_bank0(1, 4);
    // Queue 0 read beats a buffered load write on bank 0
    w = {$urandom, $urandom};
    queue_ready[0] <= 1'b0;
    issue_request(0, 0, 5, 8'd1, EW64, '0);
    ldu_req <= 1'b1;
    ldu_wb  <= '{id: 2'd3, addr: 8'd12, wdata: w, be: '1};
    @(negedge clk);
    expect_true(ldu_gnt, "load write refused by an empty buffer");
    @(posedge clk);
    ldu_req        <= 1'b0;
    queue_ready[0] <= 1'b1;
    @(negedge clk);
    expect_true(issued[0] && !vrf_acc[0].wen, "read lost to the load write");
    @(negedge clk);
    expect_true(vrf_acc[0].wen && vrf_acc[0].wdata == w, "load write not served after read");
    contend_bank0(0, 1);
    contend_bank0(0, 2);
    run_read(0, 6, 8'd1, EW64, '0);
    contend_bank0(0, 3);
    finish_test("priority");
  endtask

  task automatic test_load_buffer();
    elem_t w1, w2;
    load_write(9);
    load_write(46);
    w1 = {$urandom, $urandom};
    w2 = {$urandom, $urandom};
    @(posedge clk);
    alu_req <= 1'b1;
    alu_wb  <= '{id: 2'd1, addr: 8'd0, wdata: '0, be: '1};
    ldu_req <= 1'b1;
    ldu_wb  <= '{id: 2'd3, addr: 8'd4, wdata: w1, be: '1};
    @(negedge clk);
    expect_true(ldu_gnt, "first buffered write refused");
    @(posedge clk);
    ldu_wb.wdata <= w2;
    repeat (3) begin
      @(negedge clk);
      expect_true(!ldu_gnt && !ldu_final, "full buffer still granting");
    end
    @(posedge clk);
    alu_req <= 1'b0;
    @(negedge clk);
    expect_true(ldu_gnt && vrf_acc[0].wdata == w1, "buffer did not drain first word");
    @(posedge clk);
    ldu_req <= 1'b0;
    @(negedge clk);
    expect_true(ldu_final && vrf_acc[0].wdata == w2, "second word not written");
    @(negedge clk);
    expect_true(ldu_final, "second final grant missing");
    finish_test("load_buffer");
  endtask

  task automatic test_hazard();
    @(negedge clk);
    rd1_cnt   = 0;
    wr2_cnt   = 0;
    hazard_on = 1'b1;
    fork
      run_read(1, 5, 8'd4, EW64, 4'b0100);
      repeat (4) begin
        repeat (5) @(posedge clk);
        alu_req <= 1'b1;
        alu_wb  <= '{id: 2'd2, addr: 8'd200, wdata: {$urandom, $urandom}, be: '1};
        @(negedge clk);
        expect_true(alu_gnt, "id-2 write not granted");
        @(posedge clk);
        alu_req <= 1'b0;
      end
    join
    hazard_on = 1'b0;
    expect_true(rd1_cnt == 4, "stalled reads did not complete");
    finish_test("hazard_stall");
  endtask

  initial begin
    void'($urandom(32'h892a));
    rst_n       = 1'b0;
    operand_req = '0;
    req_valid   = '0;
    queue_ready = '1;
    alu_wb      = '0;
    alu_req     = 1'b0;
    ldu_wb      = '0;
    ldu_req     = 1'b0;
    errors      = 0;
    test_errors = 0;
    failed_tests = 0;
    last_high   = 1'b1;
    rd1_cnt     = 0;
    wr2_cnt     = 0;
    hazard_on   = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    test_single_read();
    test_word_count();
    test_priority();
    test_load_buffer();
    test_hazard();
    $display("%0d tests, %0d failed, %0d errors", NR_TESTS, failed_tests, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
verilog/vrf_pkg.sv
verilog/opstage_pkg.sv
verilog/operand_requester.sv
verilog/result_stream_reg.sv
verilog/vrf_bank_arbiter.sv
verilog/operand_stage.sv
verif/tb_operand_stage.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_operand_stage
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

FILELIST := compile.f
SRCS     := $(shell cat $(FILELIST))
SIM      := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf $(BUILD_DIR)
